// ==== all.f ====
common/ppc_cmp_pkg.sv
hw/cmp_decoder.sv
reservation_station/reservation_station.sv
hw/cmp_unit.sv
hw/cr_writeback.sv
hw/cmp_wrapper.sv
hw/cmp_subsystem_top.sv
testbench/cmp_asserts.sv
testbench/cmp_tb.sv

// ==== Makefile ====
# Verilator build and run of the compare subsystem testbench

VERILATOR ?= verilator
TOP       ?= cmp_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Done: errors found

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/cmp_tb.sv ====
// Testbench for the compare subsystem, table driven with a scoreboard keyed by station id
`timescale 1ns/1ps

module cmp_tb;

    typedef enum int {K_CMP, K_CMPL, K_CMPI, K_CMPLI, K_BAD_L, K_BAD_OP} kind_e;

    logic        clk, rst_n, in_valid, in_ready, illegal, ra_valid, rb_valid, so_value, so_valid;
    logic [0:31] instr, ra_value, rb_value, upd_op_value, cr, model_cr;
    logic [0:3]  ra_rs_id, rb_rs_id, so_rs_id, id_taken, upd_op_rs_id, upd_so_rs_id;
    logic        upd_op_valid, upd_so_valid, upd_so_value, result_valid, result_ready;
    logic [0:3]  result_rs_id, result_cond, held_id, held_cond;
    logic [0:2]  result_crf, held_crf;
    logic        held_valid, table_done;

    string       t_name [32];
    logic [0:31] t_instr [32], t_ra [32], t_rb [32];
    logic        t_so [32], t_bad [32];
    logic [0:2]  t_vld [32], t_crf [32];       // Present at take, order ra rb so
    logic [0:3]  t_tag_ra [32], t_tag_rb [32], t_tag_so [32], t_cond [32];
    int          n_entries = 0, cur, value_errors = 0, other_errors = 0;
    int          pend_idx [$];                 // Table index of each taken compare
    logic [0:3]  pend_id [$];                  // Station id it was given
    string       last_name;
    integer      seed = 7872;

    cmp_subsystem_top dut0 (.*);

    // Flipping the sign bit maps signed order onto unsigned order
    function automatic logic [0:3] rule_cond(logic [0:31] a, logic [0:31] b, logic sgn, logic so);
        logic [0:31] ka, kb;
        ka = sgn ? {~a[0], a[1:31]} : a;
        kb = sgn ? {~b[0], b[1:31]} : b;
        return {ka < kb, ka > kb, ka == kb, so};
    endfunction

    task automatic add_entry(string name, kind_e kind, logic [0:2] bf, logic [0:31] ra,
                             logic [0:31] rb, logic so, logic [0:2] vld, logic [0:3] tag_ra,
                             logic [0:3] tag_rb, logic [0:3] tag_so);
        logic [0:31] w, op2;
        logic        sgn, imm;
        w        = '0;
        w[6:8]   = bf;                           // BF
        w[11:15] = 5'd3;                         // rA number, unused here
        op2      = rb;
        sgn      = (kind == K_CMP || kind == K_CMPI);
        imm      = (kind == K_CMPI || kind == K_CMPLI);
        case (kind)
            K_CMPI: begin
                w[0:5]   = 6'd11;
                w[16:31] = rb[16:31];
                op2      = {{16{rb[16]}}, rb[16:31]};  // SI sign extended
            end
            K_CMPLI: begin
                w[0:5]   = 6'd10;
                w[16:31] = rb[16:31];
                op2      = {16'h0000, rb[16:31]};      // UI zero extended
            end
            K_CMPL: begin
                w[0:5]   = 6'd31;
                w[21:30] = 10'd32;
            end
            K_BAD_OP: w[0:5] = 6'd14;              // addi
            default: begin
                w[0:5] = 6'd31;                    // cmp, XO 0
                w[10]  = (kind == K_BAD_L);
            end
        endcase
        t_name[n_entries]   = name;
        t_instr[n_entries]  = w;
        t_ra[n_entries]     = ra;
        t_rb[n_entries]     = rb;
        t_so[n_entries]     = so;
        t_vld[n_entries]    = imm ? {vld[0], 1'b1, vld[2]} : vld;
        t_tag_ra[n_entries] = tag_ra;
        t_tag_rb[n_entries] = tag_rb;
        t_tag_so[n_entries] = tag_so;
        t_bad[n_entries]    = (kind == K_BAD_L || kind == K_BAD_OP);
        t_cond[n_entries]   = rule_cond(ra, op2, sgn, so);
        t_crf[n_entries]    = bf;
        n_entries++;
    endtask

    task automatic build_table;
        logic [0:31] a;
        int          i;
        add_entry("cmp_neg_pos", K_CMP, 3'd0, 32'hFFFF_FFFB, 32'd3, 1'b0, 3'b111, 0, 0, 0);
        add_entry("cmpl_neg_pos", K_CMPL, 3'd1, 32'hFFFF_FFFB, 32'd3, 1'b0, 3'b111, 0, 0, 0);
        add_entry("cmp_equal_so", K_CMP, 3'd2, 32'h1234, 32'h1234, 1'b1, 3'b111, 0, 0, 0);
        add_entry("cmpl_msb", K_CMPL, 3'd3, 32'd1, 32'h8000_0000, 1'b0, 3'b111, 0, 0, 0);
        add_entry("cmpi_neg_imm", K_CMPI, 3'd4, 32'd0, 32'hFFFF, 1'b0, 3'b111, 0, 0, 0);
        add_entry("cmpli_neg_imm", K_CMPLI, 3'd5, 32'd0, 32'hFFFF, 1'b0, 3'b111, 0, 0, 0);
        add_entry("cmpi_eq_min", K_CMPI, 3'd6, 32'hFFFF_8000, 32'h8000, 1'b1, 3'b111, 0, 0, 0);
        add_entry("cmpli_gt", K_CMPLI, 3'd7, 32'hFFFF_8000, 32'h8000, 1'b0, 3'b111, 0, 0, 0);
        add_entry("bad_l_bit", K_BAD_L, 3'd0, 32'd1, 32'd2, 1'b0, 3'b111, 0, 0, 0);
        add_entry("wake_ra_so", K_CMP, 3'd2, 32'd7, 32'd7, 1'b1, 3'b010, 4'd1, 0, 4'd2);
        add_entry("wake_rb", K_CMPL, 3'd0, 32'h10, 32'hFFFF_FFF0, 1'b0, 3'b101, 0, 4'd3, 0);
        add_entry("bad_opcode", K_BAD_OP, 3'd3, 32'd5, 32'd5, 1'b1, 3'b111, 0, 0, 0);
        add_entry("wake_all", K_CMP, 3'd1, -32'sd100, 32'd50, 1'b1, 3'b000, 4'd4, 4'd5, 4'd6);
        add_entry("wake_imm", K_CMPI, 3'd3, 32'd5, 32'd5, 1'b1, 3'b011, 4'd7, 0, 0);
        for (i = 0; i < 6; i++) begin
            a = $random(seed);
            add_entry($sformatf("rand_%0d", i), i[0] ? K_CMPL : K_CMP, 3'(i), a,
                      (i == 2) ? a : $random(seed), i[1], 3'b111, 0, 0, 0);
        end
    endtask

    task automatic pulse_gpr(logic [0:3] tag, logic [0:31] value);
        upd_op_valid <= 1'b1;
        upd_op_rs_id <= tag;
        upd_op_value <= value;
        @(posedge clk);
        upd_op_valid <= 1'b0;
    endtask

    task automatic pulse_so(logic [0:3] tag, logic value);
        upd_so_valid <= 1'b1;
        upd_so_rs_id <= tag;
        upd_so_value <= value;
        @(posedge clk);
        upd_so_valid <= 1'b0;
    endtask

    task automatic apply_entry(int n);
        in_valid <= 1'b1;
        cur      <= n;
        instr    <= t_instr[n];
        ra_valid <= t_vld[n][0];
        ra_rs_id <= t_tag_ra[n];
        ra_value <= t_vld[n][0] ? t_ra[n] : ~t_ra[n];   // Junk until the broadcast
        rb_valid <= t_vld[n][1];
        rb_rs_id <= t_tag_rb[n];
        rb_value <= t_vld[n][1] ? t_rb[n] : ~t_rb[n];
        so_valid <= t_vld[n][2];
        so_rs_id <= t_tag_so[n];
        so_value <= t_vld[n][2] ? t_so[n] : ~t_so[n];
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        in_valid <= 1'b0;
        if (t_vld[n] != 3'b111 && !t_bad[n]) begin
            repeat (2) @(posedge clk);
            if (!t_vld[n][0]) pulse_gpr(t_tag_ra[n], t_ra[n]);
            if (!t_vld[n][1]) pulse_gpr(t_tag_rb[n], t_rb[n]);
            if (!t_vld[n][2]) pulse_so(t_tag_so[n], t_so[n]);
        end
    endtask

    // ##################################################
    // Clock, back-pressure and watchdog
    // ##################################################

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;                   // 20 ns period
    end

    initial begin : backpressure
        result_ready <= 1'b0;
        forever begin
            @(posedge clk);
            result_ready <= ($random(seed) & 3) != 0;   // Low about one cycle in four
        end
    end

    initial begin : watchdog
        wait (table_done);
        repeat (10 + 100 * n_entries) @(posedge clk);
        $display("Timeout: compares still outstanding after %0d cycles", 10 + 100 * n_entries);
        $display("Done: errors found");
        $finish;
    end

    // ##################################################
    // Monitor and scoreboard
    // ##################################################

    initial begin : monitor
        int i, k, n;
        model_cr   = '0;
        held_valid = 1'b0;
        last_name  = "reset";
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (cr != model_cr) begin
                    value_errors++;
                    $display("Fail cr after %s: expected %h, actual %h", last_name, model_cr, cr);
                end
                if (held_valid && (!result_valid || result_rs_id != held_id
                                   || result_crf != held_crf || result_cond != held_cond)) begin
                    other_errors++;
                    $display("Result outputs changed while result_ready was low");
                end
                if (in_valid && in_ready) begin
                    if (illegal != t_bad[cur]) begin
                        value_errors++;
                        $display("Fail %s illegal: expected %0d, actual %0d", t_name[cur],
                                 t_bad[cur], illegal);
                    end
                    if (!t_bad[cur]) begin
                        if (id_taken < 4'd8 || id_taken > 4'd11) begin   // Slot ids 8 to 11
                            value_errors++;
                            $display("Fail %s id_taken: expected 8 to 11, actual %0d",
                                     t_name[cur], id_taken);
                        end
                        pend_id.push_back(id_taken);
                        pend_idx.push_back(cur);
                    end
                end
                if (result_valid && result_ready) begin
                    k = -1;
                    for (i = 0; i < pend_id.size(); i++) begin
                        if (k < 0 && pend_id[i] == result_rs_id) k = i;   // Oldest first
                    end
                    if (k < 0) begin
                        other_errors++;
                        $display("Result for id %0d arrived with no compare pending",
                                 result_rs_id);
                    end else begin
                        n = pend_idx[k];
                        if (result_cond != t_cond[n] || result_crf != t_crf[n]) begin
                            value_errors++;
                            $display("Fail %s: expected %h in field %0d, actual %h in field %0d",
                                     t_name[n], t_cond[n], t_crf[n], result_cond, result_crf);
                        end
                        model_cr[{t_crf[n], 2'b00} +: 4] = t_cond[n];
                        last_name = t_name[n];
                        pend_id.delete(k);
                        pend_idx.delete(k);
                    end
                end
                held_valid = result_valid && !result_ready;
                held_id    = result_rs_id;
                held_crf   = result_crf;
                held_cond  = result_cond;
            end
        end
    end

    // ##################################################
    // Stimulus and final report
    // ##################################################

    initial begin : stimulus
        rst_n <= 1'b0;
        in_valid <= 1'b0;
        cur <= 0;
        instr <= '0;
        ra_value <= '0;
        ra_valid <= 1'b0;
        ra_rs_id <= '0;
        rb_value <= '0;
        rb_valid <= 1'b0;
        rb_rs_id <= '0;
        so_value <= 1'b0;
        so_valid <= 1'b0;
        so_rs_id <= '0;
        upd_op_valid <= 1'b0;
        upd_op_rs_id <= '0;
        upd_op_value <= '0;
        upd_so_valid <= 1'b0;
        upd_so_rs_id <= '0;
        upd_so_value <= 1'b0;
        build_table();
        table_done = 1'b1;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int n = 0; n < n_entries; n++) apply_entry(n);
        @(negedge clk);
        while (pend_id.size() != 0) @(negedge clk);   // Every taken id answered
        repeat (4) @(negedge clk);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== testbench/cmp_asserts.sv ====
// Bound checks on result handshake stability, dropped instructions and reset state
`timescale 1ns/1ps

module cmp_asserts (
    input logic       clk,
    input logic       rst_n,
    input logic       in_ready,
    input logic       illegal,
    input logic [0:3] free_slots,
    input logic       result_valid,
    input logic       result_ready,
    input logic [0:3] result_rs_id,
    input logic [0:2] result_crf,
    input logic [0:3] result_cond
);

    // Stalled result holds id, field and condition
    assert property (@(posedge clk) disable iff (!rst_n)
        result_valid && !result_ready |=> result_valid && $stable(result_rs_id)
            && $stable(result_crf) && $stable(result_cond))
        else $error("Result outputs changed while result_ready was low");

    // Dropped instr never moves a slot out of FREE
    assert property (@(posedge clk) disable iff (!rst_n)
        illegal |=> ($past(free_slots) & ~free_slots) == '0)
        else $error("Illegal pulse coincided with a station take");

    assert property (@(posedge clk) $rose(rst_n) |-> !in_ready && !result_valid)
        else $error("in_ready or result_valid high right after reset");

endmodule

bind cmp_subsystem_top cmp_asserts asrt0 (
    .clk(clk), .rst_n(rst_n), .in_ready(in_ready), .illegal(illegal),
    .free_slots({wrap0.rs0.state_q[0] == ppc_cmp_pkg::SLOT_FREE,
                 wrap0.rs0.state_q[1] == ppc_cmp_pkg::SLOT_FREE,
                 wrap0.rs0.state_q[2] == ppc_cmp_pkg::SLOT_FREE,
                 wrap0.rs0.state_q[3] == ppc_cmp_pkg::SLOT_FREE}),   // One flag per slot
    .result_valid(result_valid), .result_ready(result_ready),
    .result_rs_id(result_rs_id), .result_crf(result_crf), .result_cond(result_cond)
);

// ==== hw/cmp_subsystem_top.sv ====
// Compare subsystem top with decode, issue-and-execute and condition register writeback
`timescale 1ns/1ps

module cmp_subsystem_top
    import ppc_cmp_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [0:31]            instr,
    input  logic [0:31]            ra_value,
    input  logic                   ra_valid,
    input  logic [0:RS_ID_WIDTH-1] ra_rs_id,
    input  logic [0:31]            rb_value,
    input  logic                   rb_valid,
    input  logic [0:RS_ID_WIDTH-1] rb_rs_id,
    input  logic                   so_value,
    input  logic                   so_valid,
    input  logic [0:RS_ID_WIDTH-1] so_rs_id,
    output logic [0:RS_ID_WIDTH-1] id_taken,
    output logic                   illegal,
    input  logic                   upd_op_valid,
    input  logic [0:RS_ID_WIDTH-1] upd_op_rs_id,
    input  logic [0:31]            upd_op_value,
    input  logic                   upd_so_valid,
    input  logic [0:RS_ID_WIDTH-1] upd_so_rs_id,
    input  logic                   upd_so_value,
    output logic                   result_valid,
    input  logic                   result_ready,
    output logic [0:RS_ID_WIDTH-1] result_rs_id,
    output logic [0:CRF_WIDTH-1]   result_crf,
    output logic [0:3]             result_cond,
    output logic [0:31]            cr
);

    cmp_mode_e            dec_mode;
    logic [0:CRF_WIDTH-1] dec_crf;
    logic [0:31]          dec_imm, op2_value;
    logic                 dec_use_imm, dec_illegal, op2_valid, take_ready;

    cmp_decoder dec0 (
        .instr(instr), .mode(dec_mode), .crf(dec_crf),
        .use_imm(dec_use_imm), .imm_value(dec_imm), .illegal(dec_illegal)
    );

    assign op2_value = dec_use_imm ? dec_imm : rb_value;       // Immediate replaces rb
    assign op2_valid = dec_use_imm || rb_valid;                // Immediate is always present
    assign illegal   = in_valid && dec_illegal;                // Always accepted, so a transfer
    assign in_ready  = take_ready || illegal;                  // Dropped instrs need no slot

    cmp_wrapper wrap0 (
        .clk(clk), .rst_n(rst_n),
        .take_valid(in_valid && !dec_illegal), .take_ready(take_ready),
        .mode_in(dec_mode), .crf_in(dec_crf),
        .op1_value(ra_value), .op1_valid(ra_valid), .op1_rs_id(ra_rs_id),
        .op2_value(op2_value), .op2_valid(op2_valid), .op2_rs_id(rb_rs_id),
        .so_value(so_value), .so_valid(so_valid), .so_rs_id(so_rs_id),
        .id_taken(id_taken),
        .upd_op_valid(upd_op_valid), .upd_op_rs_id(upd_op_rs_id), .upd_op_value(upd_op_value),
        .upd_so_valid(upd_so_valid), .upd_so_rs_id(upd_so_rs_id), .upd_so_value(upd_so_value),
        .output_valid(result_valid), .output_ready(result_ready),
        .rs_id_out(result_rs_id), .crf_out(result_crf), .result(result_cond)
    );

    cr_writeback crwb0 (
        .clk(clk), .rst_n(rst_n),
        .wb_valid(result_valid && result_ready),               // Only on the accepted transfer
        .wb_crf(result_crf), .wb_cond(result_cond), .cr(cr)
    );

endmodule

// ==== hw/cmp_wrapper.sv ====
// Issue-and-execute block joining the reservation station to the compare unit
`timescale 1ns/1ps

module cmp_wrapper
    import ppc_cmp_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   take_valid,
    output logic                   take_ready,
    input  cmp_mode_e              mode_in,
    input  logic [0:CRF_WIDTH-1]   crf_in,
    input  logic [0:31]            op1_value,
    input  logic                   op1_valid,
    input  logic [0:RS_ID_WIDTH-1] op1_rs_id,
    input  logic [0:31]            op2_value,
    input  logic                   op2_valid,
    input  logic [0:RS_ID_WIDTH-1] op2_rs_id,
    input  logic                   so_value,
    input  logic                   so_valid,
    input  logic [0:RS_ID_WIDTH-1] so_rs_id,
    output logic [0:RS_ID_WIDTH-1] id_taken,
    input  logic                   upd_op_valid,
    input  logic [0:RS_ID_WIDTH-1] upd_op_rs_id,
    input  logic [0:31]            upd_op_value,
    input  logic                   upd_so_valid,
    input  logic [0:RS_ID_WIDTH-1] upd_so_rs_id,
    input  logic                   upd_so_value,
    output logic                   output_valid,
    input  logic                   output_ready,
    output logic [0:RS_ID_WIDTH-1] rs_id_out,
    output logic [0:CRF_WIDTH-1]   crf_out,
    output logic [0:3]             result
);

    logic                   iss_valid, iss_ready, iss_so;
    logic [0:31]            iss_op1, iss_op2;
    cmp_mode_e              iss_mode;
    logic [0:CRF_WIDTH-1]   iss_crf;
    logic [0:RS_ID_WIDTH-1] iss_rs_id;

    reservation_station rs0 (
        .clk(clk), .rst_n(rst_n),
        .take_valid(take_valid), .take_ready(take_ready),
        .mode_in(mode_in), .crf_in(crf_in),
        .op1_value(op1_value), .op1_valid(op1_valid), .op1_rs_id(op1_rs_id),
        .op2_value(op2_value), .op2_valid(op2_valid), .op2_rs_id(op2_rs_id),
        .so_value(so_value), .so_valid(so_valid), .so_rs_id(so_rs_id),
        .id_taken(id_taken),
        .upd_op_valid(upd_op_valid), .upd_op_rs_id(upd_op_rs_id), .upd_op_value(upd_op_value),
        .upd_so_valid(upd_so_valid), .upd_so_rs_id(upd_so_rs_id), .upd_so_value(upd_so_value),
        .issue_valid(iss_valid), .issue_ready(iss_ready),         // Stalls on unit back-pressure
        .issue_op1(iss_op1), .issue_op2(iss_op2), .issue_so(iss_so),
        .issue_mode(iss_mode), .issue_crf(iss_crf), .issue_rs_id(iss_rs_id)
    );

    cmp_unit cmp0 (
        .clk(clk), .rst_n(rst_n),
        .input_valid(iss_valid), .input_ready(iss_ready),
        .op1(iss_op1), .op2(iss_op2), .so(iss_so), .mode(iss_mode),
        .crf_in(iss_crf), .rs_id_in(iss_rs_id),
        .output_valid(output_valid), .output_ready(output_ready),
        .rs_id_out(rs_id_out), .crf_out(crf_out), .result(result)
    );

endmodule

// ==== hw/cr_writeback.sv ====
// Condition register updated one 4-bit field at a time from accepted results
`timescale 1ns/1ps

module cr_writeback
    import ppc_cmp_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 wb_valid,
    input  logic [0:CRF_WIDTH-1] wb_crf,
    input  logic [0:3]           wb_cond,
    output logic [0:31]          cr
);

    logic [0:31] cr_next;

    // Field k is bits 4k..4k+3, bit 0 being the MSB
    always_comb begin
        cr_next = cr;
        if (wb_valid) begin
            cr_next[4 * wb_crf +: 4] = wb_cond;    // Only the addressed field
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cr <= '0;
        end else begin
            cr <= cr_next;
        end
    end

endmodule

// ==== hw/cmp_unit.sv ====
// Compare unit producing LT, GT, EQ and SO into a held output register
`timescale 1ns/1ps

module cmp_unit
    import ppc_cmp_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   input_valid,
    output logic                   input_ready,
    input  logic [0:31]            op1,
    input  logic [0:31]            op2,
    input  logic                   so,
    input  cmp_mode_e              mode,
    input  logic [0:CRF_WIDTH-1]   crf_in,
    input  logic [0:RS_ID_WIDTH-1] rs_id_in,
    output logic                   output_valid,
    input  logic                   output_ready,
    output logic [0:RS_ID_WIDTH-1] rs_id_out,
    output logic [0:CRF_WIDTH-1]   crf_out,
    output logic [0:3]             result
);

    logic lt, gt, eq;
    logic accept;

    always_comb begin
        if (mode == CMP_SIGNED) begin
            lt = $signed(op1) < $signed(op2);
            gt = $signed(op1) > $signed(op2);
        end else begin
            lt = op1 < op2;
            gt = op1 > op2;
        end
        eq = op1 == op2;
    end

    assign input_ready = !output_valid || output_ready;  // Free or draining this cycle
    assign accept      = input_valid && input_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            output_valid <= 1'b0;
        end else if (accept) begin
            output_valid <= 1'b1;
        end else if (output_ready) begin
            output_valid <= 1'b0;                        // Result taken, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result    <= {lt, gt, eq, so};               // CR field order LT GT EQ SO
            rs_id_out <= rs_id_in;
            crf_out   <= crf_in;
        end
    end

endmodule

// ==== reservation_station/reservation_station.sv ====
// Reservation station holding compares until ra, second operand and SO are all present
`timescale 1ns/1ps

module reservation_station
    import ppc_cmp_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   take_valid,
    output logic                   take_ready,
    input  cmp_mode_e              mode_in,
    input  logic [0:CRF_WIDTH-1]   crf_in,
    input  logic [0:31]            op1_value,
    input  logic                   op1_valid,
    input  logic [0:RS_ID_WIDTH-1] op1_rs_id,
    input  logic [0:31]            op2_value,
    input  logic                   op2_valid,
    input  logic [0:RS_ID_WIDTH-1] op2_rs_id,
    input  logic                   so_value,
    input  logic                   so_valid,
    input  logic [0:RS_ID_WIDTH-1] so_rs_id,
    output logic [0:RS_ID_WIDTH-1] id_taken,
    input  logic                   upd_op_valid,
    input  logic [0:RS_ID_WIDTH-1] upd_op_rs_id,
    input  logic [0:31]            upd_op_value,
    input  logic                   upd_so_valid,
    input  logic [0:RS_ID_WIDTH-1] upd_so_rs_id,
    input  logic                   upd_so_value,
    output logic                   issue_valid,
    input  logic                   issue_ready,
    output logic [0:31]            issue_op1,
    output logic [0:31]            issue_op2,
    output logic                   issue_so,
    output cmp_mode_e              issue_mode,
    output logic [0:CRF_WIDTH-1]   issue_crf,
    output logic [0:RS_ID_WIDTH-1] issue_rs_id
);

    slot_state_e              state_q [RS_DEPTH], state_d [RS_DEPTH];
    logic [0:31]              op1_q [RS_DEPTH], op1_d [RS_DEPTH];
    logic [0:31]              op2_q [RS_DEPTH], op2_d [RS_DEPTH];
    logic                     so_q [RS_DEPTH], so_d [RS_DEPTH];
    logic [0:RS_ID_WIDTH-1]   op1_tag_q [RS_DEPTH], op1_tag_d [RS_DEPTH];
    logic [0:RS_ID_WIDTH-1]   op2_tag_q [RS_DEPTH], op2_tag_d [RS_DEPTH];
    logic [0:RS_ID_WIDTH-1]   so_tag_q [RS_DEPTH], so_tag_d [RS_DEPTH];
    logic [0:RS_DEPTH-1]      op1_vld_q, op1_vld_d, op2_vld_q, op2_vld_d, so_vld_q, so_vld_d;
    cmp_mode_e                mode_q [RS_DEPTH];
    logic [0:CRF_WIDTH-1]     crf_q [RS_DEPTH];
    logic [SLOT_IDX_WIDTH-1:0] free_idx, ready_idx;
    logic                     ready_any, free_next, take_fire, issue_fire;

    // ##################################################
    // Slot selection, lowest index wins
    // ##################################################

    always_comb begin
        free_idx  = '0;
        ready_idx = '0;
        ready_any = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (state_q[i] == SLOT_FREE) free_idx = SLOT_IDX_WIDTH'(i);
            if (state_q[i] == SLOT_READY) begin
                ready_idx = SLOT_IDX_WIDTH'(i);
                ready_any = 1'b1;
            end
        end
    end

    assign take_fire   = take_valid && take_ready;
    assign issue_fire  = issue_valid && issue_ready;
    assign id_taken    = RS_ID_WIDTH'(RS_OFFSET + free_idx);   // Tag of the slot being filled
    assign issue_valid = ready_any;
    assign issue_op1   = op1_q[ready_idx];
    assign issue_op2   = op2_q[ready_idx];
    assign issue_so    = so_q[ready_idx];
    assign issue_mode  = mode_q[ready_idx];
    assign issue_crf   = crf_q[ready_idx];
    assign issue_rs_id = RS_ID_WIDTH'(RS_OFFSET + ready_idx);

    // ##################################################
    // Next slot contents, take and broadcast capture
    // ##################################################

    always_comb begin
        logic take_here;
        free_next = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            take_here    = take_fire && (free_idx == SLOT_IDX_WIDTH'(i));
            op1_d[i]     = take_here ? op1_value : op1_q[i];     // New instr or held value
            op1_tag_d[i] = take_here ? op1_rs_id : op1_tag_q[i];
            op1_vld_d[i] = take_here ? op1_valid : op1_vld_q[i];
            op2_d[i]     = take_here ? op2_value : op2_q[i];
            op2_tag_d[i] = take_here ? op2_rs_id : op2_tag_q[i];
            op2_vld_d[i] = take_here ? op2_valid : op2_vld_q[i];
            so_d[i]      = take_here ? so_value : so_q[i];
            so_tag_d[i]  = take_here ? so_rs_id : so_tag_q[i];
            so_vld_d[i]  = take_here ? so_valid : so_vld_q[i];
            if (!op1_vld_d[i] && upd_op_valid && upd_op_rs_id == op1_tag_d[i]) begin
                op1_d[i]     = upd_op_value;                     // GPR broadcast hit
                op1_vld_d[i] = 1'b1;
            end
            if (!op2_vld_d[i] && upd_op_valid && upd_op_rs_id == op2_tag_d[i]) begin
                op2_d[i]     = upd_op_value;
                op2_vld_d[i] = 1'b1;
            end
            if (!so_vld_d[i] && upd_so_valid && upd_so_rs_id == so_tag_d[i]) begin
                so_d[i]     = upd_so_value;                      // SO broadcast hit
                so_vld_d[i] = 1'b1;
            end
            state_d[i] = state_q[i];
            if (take_here) begin
                state_d[i] = SLOT_WAIT;                          // Always one cycle in WAIT
            end else if (issue_fire && ready_idx == SLOT_IDX_WIDTH'(i)) begin
                state_d[i] = SLOT_FREE;                          // Freed on issue
            end else if (state_q[i] == SLOT_WAIT && op1_vld_d[i] && op2_vld_d[i]
                         && so_vld_d[i]) begin
                state_d[i] = SLOT_READY;
            end
            if (state_d[i] == SLOT_FREE) free_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            op1_q[i]     <= op1_d[i];
            op2_q[i]     <= op2_d[i];
            so_q[i]      <= so_d[i];
            op1_tag_q[i] <= op1_tag_d[i];
            op2_tag_q[i] <= op2_tag_d[i];
            so_tag_q[i]  <= so_tag_d[i];
            if (take_fire && free_idx == SLOT_IDX_WIDTH'(i)) begin
                mode_q[i] <= mode_in;
                crf_q[i]  <= crf_in;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < RS_DEPTH; i++) state_q[i] <= SLOT_FREE;
            op1_vld_q  <= '0;
            op2_vld_q  <= '0;
            so_vld_q   <= '0;
            take_ready <= 1'b0;                                  // Low until out of reset
        end else begin
            state_q    <= state_d;
            op1_vld_q  <= op1_vld_d;
            op2_vld_q  <= op2_vld_d;
            so_vld_q   <= so_vld_d;
            take_ready <= free_next;                             // Registered free-slot flag
        end
    end

endmodule

// ==== hw/cmp_decoder.sv ====
// Compare decoder turning an instruction word into mode, target field and immediate
`timescale 1ns/1ps

module cmp_decoder
    import ppc_cmp_pkg::*;
(
    input  logic [0:31]          instr,
    output cmp_mode_e            mode,
    output logic [0:CRF_WIDTH-1] crf,
    output logic                 use_imm,
    output logic [0:31]          imm_value,
    output logic                 illegal
);

    primary_op_e opcode;
    logic [0:9]  xo;
    logic        l_bit;

    assign opcode = primary_op_e'(instr[0:5]); // Primary opcode, big-endian bits 0..5
    assign xo     = instr[21:30];              // Extended opcode of the X form
    assign l_bit  = instr[10];                 // 64-bit compare request
    assign crf    = instr[6:8];                // BF, target CR field

    always_comb begin
        mode      = CMP_SIGNED;
        use_imm   = 1'b0;
        imm_value = {{16{instr[16]}}, instr[16:31]}; // Sign extended SI
        illegal   = l_bit;                           // L set is not supported

        case (opcode)
            OPC_CMPI: begin
                use_imm = 1'b1;
            end
            OPC_CMPLI: begin
                mode      = CMP_UNSIGNED;
                use_imm   = 1'b1;
                imm_value = {16'b0, instr[16:31]};   // Zero extended UI
            end
            OPC_EXT31: begin
                if (xo == EXT_XO_CMPL) begin
                    mode = CMP_UNSIGNED;
                end else if (xo != EXT_XO_CMP) begin
                    illegal = 1'b1;                  // Some other opcode-31 instr
                end
            end
            default: begin
                illegal = 1'b1;                      // Not a compare at all
            end
        endcase
    end

endmodule

// ==== common/ppc_cmp_pkg.sv ====
// Compare subsystem package with opcode, mode and slot encodings and station sizing
package ppc_cmp_pkg;

    // ##################################################
    // Instruction encodings
    // ##################################################

    typedef enum logic [5:0] {
        OPC_CMPLI = 6'd10,                      // Unsigned compare with immediate
        OPC_CMPI  = 6'd11,                      // Signed compare with immediate
        OPC_EXT31 = 6'd31                       // Register forms, XO selects
    } primary_op_e;

    localparam logic [0:9] EXT_XO_CMP  = 10'd0;  // cmp, signed
    localparam logic [0:9] EXT_XO_CMPL = 10'd32; // cmpl, unsigned

    typedef enum logic {
        CMP_SIGNED   = 1'b0,
        CMP_UNSIGNED = 1'b1
    } cmp_mode_e;

    // ##################################################
    // Reservation station
    // ##################################################

    typedef enum logic [1:0] {
        SLOT_FREE  = 2'd0,                      // Empty, may be taken
        SLOT_WAIT  = 2'd1,                      // Holds instr, operands pending
        SLOT_READY = 2'd2                       // All operands present
    } slot_state_e;

    localparam int RS_DEPTH       = 4;                  // Slots in the station
    localparam int RS_ID_WIDTH    = 4;                  // Producer and station tag width
    localparam int RS_OFFSET      = 8;                  // Id of slot 0
    localparam int SLOT_IDX_WIDTH = $clog2(RS_DEPTH);   // Slot index width
    localparam int CRF_WIDTH      = 3;                  // CR field index width

endpackage
